// File: logic/iq_consts.svh
/* instruction queue constants */

`ifndef IQ_CONSTS_SVH
`define IQ_CONSTS_SVH

// ========================================
// queue geometry
// ========================================

// number of queue entries, power of two
`define IQ_ENTRIES 8

// index width, log2 of the depth
`define IQ_NDX_W 3

// ========================================
// instruction fields
// ========================================

// target register number width
`define IQ_REG_W 5

`endif

// File: logic/iq_pkg.sv
/* instruction queue types */

package iq_pkg;

    `include "iq_consts.svh"

    // position in the circular queue
    typedef logic [`IQ_NDX_W-1:0] que_ndx_t;

    // one queued instruction, 23 bits
    typedef struct packed {
        logic [15:0]          op_tag;
        logic [`IQ_REG_W-1:0] tgt;
        logic                 is_br;
        logic                 backbr;
    } iq_insn_t;

    // two-wide group from fetch, slot_v[0] belongs to insn0
    typedef struct packed {
        logic [1:0] slot_v;
        iq_insn_t   insn0;
        iq_insn_t   insn1;
    } fetch_grp_t;

    // done report from an execution unit
    typedef struct packed {
        que_ndx_t ndx;
    } wb_t;

    // retire record, cnt of 1 means only insn0 counts
    typedef struct packed {
        logic [1:0] cnt;
        iq_insn_t   insn0;
        iq_insn_t   insn1;
    } commit_t;

    typedef enum logic [1:0] {
        ST_RUN     = 2'd0,
        ST_RECOVER = 2'd1,
        ST_HALT    = 2'd2
    } iq_state_t;

    // slots that really enter the queue
    // a backwards branch in slot 0 kills slot 1
    function automatic logic [1:0] grp_keep(input fetch_grp_t grp);
        logic [1:0] keep;
        keep[0] = grp.slot_v[0];
        keep[1] = grp.slot_v[1] && !(grp.slot_v[0] && grp.insn0.backbr);
        return keep;
    endfunction

endpackage

// File: logic/iq_ctrl.sv
/* queue control FSM */

`timescale 1ns/1ns

module iq_ctrl (
    input  logic              clk,
    input  logic              rst,
    input  logic              miss_valid,
    input  logic [3:0]        panic,
    output iq_pkg::iq_state_t state,
    output logic              enq_open,
    output logic              retire_en
);
    import iq_pkg::*;

    iq_state_t state_nx;

    // ========================================
    // next state
    // ========================================
    always_comb begin
        state_nx = state;
        // a miss wins over everything else
        if (miss_valid) begin
            state_nx = ST_RECOVER;
        end else begin
            case (state)
                ST_RUN: begin
                    if (|panic)
                        state_nx = ST_HALT;
                end
                // recover only ever lasts one cycle
                ST_RECOVER: begin
                    state_nx = (|panic) ? ST_HALT : ST_RUN;
                end
                ST_HALT: begin
                    if (~|panic)
                        state_nx = ST_RUN;
                end
                default: begin
                    state_nx = ST_RUN;
                end
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ST_RUN;
        end else begin
            state <= state_nx;
        end
    end

    // ========================================
    // permissions
    // ========================================
    // fetch waits while the tail is being rewound
    assign enq_open = (state != ST_RECOVER);
    // panic also blocks at once, before the halt state is reached
    assign retire_en = (state != ST_HALT) && (~|panic);

endmodule

// File: logic/iq_ptrs.sv
/* head and tail pointers */

`timescale 1ns/1ns

`include "iq_consts.svh"

module iq_ptrs (
    input  logic             clk,
    input  logic             rst,
    input  logic [1:0]       enq_cnt,
    input  logic [1:0]       ret_cnt,
    input  logic             miss_valid,
    input  iq_pkg::que_ndx_t miss_ndx,
    output iq_pkg::que_ndx_t head0,
    output iq_pkg::que_ndx_t head1,
    output iq_pkg::que_ndx_t tail,
    output logic [3:0]       free_cnt
);
    import iq_pkg::*;

    // index plus one wrap bit
    localparam int PW = `IQ_NDX_W + 1;

    logic [PW-1:0] head_q;
    logic [PW-1:0] tail_q;
    logic [PW-1:0] used;
    // distance from the oldest entry to the missed branch
    que_ndx_t      miss_dist;

    assign miss_dist = miss_ndx - head_q[`IQ_NDX_W-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= head_q + PW'(ret_cnt);
            // rewind to just past the branch, measured from the old head
            // so the wrap bit stays right
            if (miss_valid)
                tail_q <= head_q + PW'(miss_dist) + PW'(1);
            else
                tail_q <= tail_q + PW'(enq_cnt);
        end
    end

    // ========================================
    // outputs
    // ========================================
    assign head0 = head_q[`IQ_NDX_W-1:0];
    assign head1 = head0 + que_ndx_t'(1);
    assign tail  = tail_q[`IQ_NDX_W-1:0];

    // equal index with differing wrap bits means full
    assign used     = tail_q - head_q;
    assign free_cnt = 4'(`IQ_ENTRIES) - 4'(used);

endmodule

// File: logic/iq_valid.sv
/* entry valid bits */

`timescale 1ns/1ns

`include "iq_consts.svh"

module iq_valid (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   enq_fire,
    input  iq_pkg::fetch_grp_t     enq_grp,
    input  iq_pkg::que_ndx_t       tail,
    input  logic                   miss_valid,
    input  iq_pkg::que_ndx_t       miss_ndx,
    input  iq_pkg::que_ndx_t       head0,
    input  iq_pkg::que_ndx_t       head1,
    input  logic [1:0]             ret_cnt,
    output logic [`IQ_ENTRIES-1:0] iq_v
);
    import iq_pkg::*;

    logic [1:0]             keep;
    que_ndx_t               slot1_ndx;
    que_ndx_t               miss_span;
    logic [`IQ_ENTRIES-1:0] set_v;
    logic [`IQ_ENTRIES-1:0] stomp;
    logic [`IQ_ENTRIES-1:0] clr_v;

    // ========================================
    // enqueue
    // ========================================
    assign keep = grp_keep(enq_grp);
    // slot 1 follows slot 0, or sits at the tail if slot 0 is empty
    assign slot1_ndx = tail + que_ndx_t'(keep[0]);

    always_comb begin
        set_v = '0;
        if (enq_fire) begin
            if (keep[0])
                set_v[tail] = 1'b1;
            if (keep[1])
                set_v[slot1_ndx] = 1'b1;
        end
    end

    // ========================================
    // stomp on branch miss
    // ========================================
    // entries from miss_ndx+1 up to tail-1 are wrong path
    assign miss_span = tail - miss_ndx;

    always_comb begin
        que_ndx_t rel;
        for (int i = 0; i < `IQ_ENTRIES; i++) begin
            rel = que_ndx_t'(i) - miss_ndx;
            // span of zero means the queue is full and the
            // branch is the oldest entry, so all others go
            stomp[i] = miss_valid && (rel != '0) &&
                       ((miss_span == '0) || (rel < miss_span));
        end
    end

    // ========================================
    // retire and update
    // ========================================
    always_comb begin
        clr_v = stomp;
        // stomp and retire only ever clear, so they merge freely
        if (ret_cnt != 2'd0)
            clr_v[head0] = 1'b1;
        if (ret_cnt == 2'd2)
            clr_v[head1] = 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            iq_v <= '0;
        end else begin
            iq_v <= (iq_v | set_v) & ~clr_v;
        end
    end

endmodule

// File: logic/iq_store.sv
/* entry payload and done bits */

`timescale 1ns/1ns

`include "iq_consts.svh"

module iq_store (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        enq_fire,
    input  iq_pkg::fetch_grp_t          enq_grp,
    input  iq_pkg::que_ndx_t            tail,
    input  logic                        wb_valid,
    input  iq_pkg::wb_t                 wb,
    input  logic [`IQ_ENTRIES-1:0]      iq_v,
    input  iq_pkg::que_ndx_t            head0,
    input  iq_pkg::que_ndx_t            head1,
    output logic [1:0]                  head_ready,
    output iq_pkg::iq_insn_t [1:0]      head_insn
);
    import iq_pkg::*;

    iq_insn_t               slots [`IQ_ENTRIES];
    logic [`IQ_ENTRIES-1:0] done;
    logic [1:0]             keep;
    que_ndx_t               slot1_ndx;

    assign keep      = grp_keep(enq_grp);
    assign slot1_ndx = tail + que_ndx_t'(keep[0]);

    // payload array
    always_ff @(posedge clk) begin
        if (enq_fire && keep[0])
            slots[tail] <= enq_grp.insn0;
        if (enq_fire && keep[1])
            slots[slot1_ndx] <= enq_grp.insn1;
    end

    // ========================================
    // done tracking
    // ========================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= '0;
        end else begin
            // late writeback to a stomped or retired slot is dropped
            if (wb_valid && iq_v[wb.ndx])
                done[wb.ndx] <= 1'b1;
            // new entries start not done
            if (enq_fire && keep[0])
                done[tail] <= 1'b0;
            if (enq_fire && keep[1])
                done[slot1_ndx] <= 1'b0;
        end
    end

    // head read out
    assign head_ready[0] = iq_v[head0] & done[head0];
    assign head_ready[1] = iq_v[head1] & done[head1];
    assign head_insn[0]  = slots[head0];
    assign head_insn[1]  = slots[head1];

endmodule

// File: logic/iq_top.sv
/* instruction queue top */

`timescale 1ns/1ns

`include "iq_consts.svh"

module iq_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               enq_valid,
    input  iq_pkg::fetch_grp_t enq_grp,
    output logic               enq_ready,
    input  logic               wb_valid,
    input  iq_pkg::wb_t        wb,
    input  logic               miss_valid,
    input  iq_pkg::que_ndx_t   miss_ndx,
    input  logic [3:0]         panic,
    output logic               cmt_valid,
    output iq_pkg::commit_t    cmt,
    input  logic               cmt_ready
);
    import iq_pkg::*;

    iq_state_t              ctrl_state;
    logic                   enq_open;
    logic                   retire_en;
    que_ndx_t               head0;
    que_ndx_t               head1;
    que_ndx_t               tail;
    logic [3:0]             free_cnt;
    logic [`IQ_ENTRIES-1:0] iq_v;
    logic [1:0]             head_ready;
    iq_insn_t [1:0]         head_insn;
    logic                   enq_fire;
    logic [1:0]             keep;
    logic [1:0]             enq_cnt;
    logic [1:0]             ret_cnt;
    // a stalled single retire stays single
    logic                   hold_one;

    // ========================================
    // enqueue handshake
    // ========================================
    // room for a full group, and no tail rewind on this edge
    assign enq_ready = enq_open && (free_cnt >= 4'd2) && !miss_valid;
    assign enq_fire  = enq_valid && enq_ready;
    assign keep      = grp_keep(enq_grp);
    assign enq_cnt   = enq_fire ? (2'(keep[0]) + 2'(keep[1])) : 2'd0;

    // ========================================
    // retire handshake
    // ========================================
    assign cmt_valid = retire_en && head_ready[0];

    always_comb begin
        cmt.cnt   = (head_ready[1] && !hold_one) ? 2'd2 : 2'd1;
        cmt.insn0 = head_insn[0];
        cmt.insn1 = head_insn[1];
    end

    assign ret_cnt = (cmt_valid && cmt_ready) ? cmt.cnt : 2'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hold_one <= 1'b0;
        end else begin
            hold_one <= cmt_valid && !cmt_ready && (cmt.cnt == 2'd1);
        end
    end

    // ========================================
    // blocks
    // ========================================
    iq_ctrl ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .miss_valid (miss_valid),
        .panic      (panic),
        .state      (ctrl_state),
        .enq_open   (enq_open),
        .retire_en  (retire_en)
    );

    iq_ptrs ptrs_i (
        .clk        (clk),
        .rst        (rst),
        .enq_cnt    (enq_cnt),
        .ret_cnt    (ret_cnt),
        .miss_valid (miss_valid),
        .miss_ndx   (miss_ndx),
        .head0      (head0),
        .head1      (head1),
        .tail       (tail),
        .free_cnt   (free_cnt)
    );

    iq_valid valid_i (
        .clk        (clk),
        .rst        (rst),
        .enq_fire   (enq_fire),
        .enq_grp    (enq_grp),
        .tail       (tail),
        .miss_valid (miss_valid),
        .miss_ndx   (miss_ndx),
        .head0      (head0),
        .head1      (head1),
        .ret_cnt    (ret_cnt),
        .iq_v       (iq_v)
    );

    iq_store store_i (
        .clk        (clk),
        .rst        (rst),
        .enq_fire   (enq_fire),
        .enq_grp    (enq_grp),
        .tail       (tail),
        .wb_valid   (wb_valid),
        .wb         (wb),
        .iq_v       (iq_v),
        .head0      (head0),
        .head1      (head1),
        .head_ready (head_ready),
        .head_insn  (head_insn)
    );

endmodule

// File: tests/iq_chk.sv
/* queue assertions */

`timescale 1ns/1ns

`include "iq_consts.svh"

module iq_chk (
    input logic                   clk,
    input logic                   rst,
    input logic [3:0]             panic,
    input logic                   miss_valid,
    input logic                   enq_ready,
    input logic                   cmt_valid,
    input iq_pkg::commit_t        cmt,
    input logic [`IQ_ENTRIES-1:0] iq_v,
    input logic [`IQ_ENTRIES-1:0] done,
    input iq_pkg::que_ndx_t       head0,
    input iq_pkg::que_ndx_t       head1
);
    // failed assertions, read by the testbench at the end
    int fail_cnt = 0;

    // panic blocks retirement at once
    a_panic_blocks: assert property (@(posedge clk) disable iff (rst)
        (panic != 4'd0) |-> !cmt_valid)
    else begin
        $error("cmt_valid high while panic is %h", panic);
        fail_cnt++;
    end

    // tail rewind cycle takes no new group
    a_miss_closes_enq: assert property (@(posedge clk) disable iff (rst)
        miss_valid |=> !enq_ready)
    else begin
        $error("enq_ready high in the cycle after a miss");
        fail_cnt++;
    end

    // a pair retire needs both head entries valid and done in the queue state
    a_pair_ready: assert property (@(posedge clk) disable iff (rst)
        (cmt_valid && (cmt.cnt == 2'd2)) |->
            (iq_v[head0] && done[head0] && iq_v[head1] && done[head1]))
    else begin
        $error("retire count 2 with valid %b done %b", iq_v, done);
        fail_cnt++;
    end

endmodule

bind iq_top iq_chk chk_i (
    .clk        (clk),
    .rst        (rst),
    .panic      (panic),
    .miss_valid (miss_valid),
    .enq_ready  (enq_ready),
    .cmt_valid  (cmt_valid),
    .cmt        (cmt),
    .iq_v       (iq_v),
    .done       (store_i.done),
    .head0      (head0),
    .head1      (head1)
);

// File: tests/iq_monitor.sv
/* retire monitor */

`timescale 1ns/1ns

module iq_monitor (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmt_valid,
    input  iq_pkg::commit_t cmt,
    input  logic            cmt_ready,
    input  logic            end_req,
    output logic            end_ack,
    output int              seen,
    output int              expect_n,
    output int              tag_errs,
    output int              other_errs
);
    logic [47:0] words [256];
    logic [15:0] exp_tags [$];

    // ========================================
    // expected retire order
    // ========================================
    // op 7 lines, nibble 10 holds how many tags follow
    initial begin
        $readmemh("tests/iq_tests.txt", words);
        for (int i = 0; i < 256; i++) begin
            if ($isunknown(words[i]) || (words[i][47:44] == 4'h0))
                break;
            if (words[i][47:44] == 4'h7) begin
                exp_tags.push_back(words[i][31:16]);
                if (words[i][43:40] == 4'h2)
                    exp_tags.push_back(words[i][15:0]);
            end
        end
        expect_n = exp_tags.size();
    end

    // next retired instruction against the head of the list
    // stimulus puts the low tag bits into the target register
    task automatic check_tag(input string name, input string tname,
                             input iq_pkg::iq_insn_t got);
        logic [4:0] exp_tgt;
        if (seen >= expect_n) begin
            $display("retired tag %h on %s after the expected list ran out",
                     got.op_tag, name);
            other_errs++;
        end else begin
            exp_tgt = exp_tags[seen][4:0];
            if (got.op_tag !== exp_tags[seen]) begin
                $display("** Error %s expected %h actual %h", name, exp_tags[seen],
                         got.op_tag);
                tag_errs++;
            end else if (got.tgt !== exp_tgt) begin
                $display("** Error %s expected %h actual %h", tname, exp_tgt, got.tgt);
                other_errs++;
            end
        end
        seen++;
    endtask

    // ========================================
    // retire watch
    // ========================================
    always @(posedge clk) begin
        if (rst) begin
            seen       = 0;
            tag_errs   = 0;
            other_errs = 0;
            end_ack    = 1'b0;
        end else begin
            if (cmt_valid && cmt_ready) begin
                if ($isunknown(cmt.cnt) || (cmt.cnt == 2'd0) || (cmt.cnt == 2'd3)) begin
                    $display("** Error cmt.cnt value %h is neither 1 nor 2", cmt.cnt);
                    other_errs++;
                end else begin
                    check_tag("cmt.insn0.op_tag", "cmt.insn0.tgt", cmt.insn0);
                    if (cmt.cnt == 2'd2)
                        check_tag("cmt.insn1.op_tag", "cmt.insn1.tgt", cmt.insn1);
                end
            end
            // closing check for tags that never came out
            if (end_req && !end_ack) begin
                if (seen < expect_n) begin
                    $display("%0d expected retirements never happened", expect_n - seen);
                    other_errs++;
                end
                end_ack = 1'b1;
            end
        end
    end

endmodule

// File: tests/iq_tb.sv
/* instruction queue testbench */

`timescale 1ns/1ns

module iq_tb;
    import iq_pkg::*;

    localparam int MAX_CMDS = 256;

    logic        clk;
    logic        rst;
    logic        enq_valid;
    fetch_grp_t  enq_grp;
    logic        enq_ready;
    logic        wb_valid;
    wb_t         wb;
    logic        miss_valid;
    que_ndx_t    miss_ndx;
    logic [3:0]  panic;
    logic        cmt_valid;
    commit_t     cmt;
    logic        cmt_ready;

    logic [47:0] cmds [MAX_CMDS];
    int          n_cmds;
    int          limit;
    int          cycles;
    int          cmd_errs;
    logic [31:0] seed_val;
    // 0 low, 1 high, 2 random
    logic [1:0]  ready_mode;
    logic        end_req;
    logic        end_ack;
    int          seen;
    int          expect_n;
    int          tag_errs;
    int          other_errs;

    iq_top iq_top_i (.*);

    iq_monitor mon_i (
        .clk        (clk),
        .rst        (rst),
        .cmt_valid  (cmt_valid),
        .cmt        (cmt),
        .cmt_ready  (cmt_ready),
        .end_req    (end_req),
        .end_ack    (end_ack),
        .seen       (seen),
        .expect_n   (expect_n),
        .tag_errs   (tag_errs),
        .other_errs (other_errs)
    );

    // ========================================
    // clock, timeout, cmt_ready
    // ========================================
    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run still busy after %0d cycles", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    // mode changes land on the following cycle
    always @(posedge clk) begin
        #1;
        if (ready_mode == 2'd2)
            cmt_ready = (($urandom % 4) != 0);
        else
            cmt_ready = ready_mode[0];
    end

    // ========================================
    // command helpers
    // ========================================
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    function automatic int count_cmds();
        int n;
        n = 0;
        while ((n < MAX_CMDS) && !$isunknown(cmds[n]) && (cmds[n][47:44] != 4'h0))
            n++;
        return n;
    endfunction

    // low tag bits double as the target register
    function automatic iq_insn_t make_insn(input logic [15:0] tag, input logic back);
        iq_insn_t insn;
        insn.op_tag = tag;
        insn.tgt    = tag[4:0];
        insn.is_br  = back;
        insn.backbr = back;
        return insn;
    endfunction

    // hold the group until enq_ready is seen mid-cycle
    task automatic enqueue_group(input logic [47:0] w);
        fetch_grp_t grp;
        grp.slot_v = w[41:40];
        grp.insn0  = make_insn(w[31:16], w[36]);
        grp.insn1  = make_insn(w[15:0], 1'b0);
        enq_grp    = grp;
        enq_valid  = 1'b1;
        #1;
        while (!enq_ready) begin
            @(posedge clk);
            #2;
        end
        next_cycle();
        enq_valid = 1'b0;
    endtask

    task automatic run_cmd(input logic [47:0] w);
        logic [15:0] arg;
        arg = w[15:0];
        case (w[47:44])
            4'h1: enqueue_group(w);
            4'h2: begin
                wb_valid = 1'b1;
                wb.ndx   = arg[2:0];
                next_cycle();
                wb_valid = 1'b0;
            end
            4'h3: begin
                miss_valid = 1'b1;
                miss_ndx   = arg[2:0];
                next_cycle();
                miss_valid = 1'b0;
            end
            4'h4: begin
                panic = arg[3:0];
                next_cycle();
            end
            4'h5: ready_mode <= arg[1:0];
            4'h6: repeat (arg) next_cycle();
            // expected tags are the monitor's business
            4'h7: ;
            default: begin
                $display("unknown command word %h in the test file", w);
                cmd_errs++;
            end
        endcase
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        enq_valid  = 1'b0;
        enq_grp    = '0;
        wb_valid   = 1'b0;
        wb         = '0;
        miss_valid = 1'b0;
        miss_ndx   = '0;
        panic      = 4'd0;
        cmt_ready  = 1'b0;
        ready_mode = 2'd2;
        end_req    = 1'b0;
        cycles     = 0;
        cmd_errs   = 0;
        seed_val   = $urandom(32'hdf6);
        $readmemh("tests/iq_tests.txt", cmds);
        n_cmds = count_cmds();
        limit  = 20 * n_cmds + 100;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int i = 0; i < n_cmds; i++)
            run_cmd(cmds[i]);
        // drain whatever is still waiting to retire
        while (seen < expect_n)
            @(negedge clk);
        repeat (4) next_cycle();
        end_req = 1'b1;
        while (!end_ack)
            @(negedge clk);
        $display("errors: %0d op_tag, %0d other, %0d command, %0d assertion",
                 tag_errs, other_errs, cmd_errs, iq_top_i.chk_i.fail_cnt);
        if ((tag_errs == 0) && (other_errs == 0) && (cmd_errs == 0) &&
            (iq_top_i.chk_i.fail_cnt == 0))
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/iq_tests.txt
// op _ slot_v or tag count _ backbr _ spare _ tag0 or - _ tag1 or arg   (hex, 48 bits)
// op: 1 enqueue, 2 writeback, 3 miss, 4 panic, 5 cmt_ready (0/1/2=random), 6 idle, 7 expected
// out of order writeback, in order retire, pairs
1_3_0_0_1001_1002
1_3_0_0_1003_1004
2_0_0_0_0000_0003
2_0_0_0_0000_0002
2_0_0_0_0000_0001
2_0_0_0_0000_0000
7_2_0_0_1001_1002
7_2_0_0_1003_1004
6_0_0_0_0000_0004
// backwards branch at index 4 drops its slot 1, writeback to empty 5 ignored
1_3_1_0_2001_2002
2_0_0_0_0000_0004
2_0_0_0_0000_0005
7_1_0_0_2001_0000
// miss at 5 stomps 6, 7 and 0, new group lands at 6
1_3_0_0_3001_3002
1_3_0_0_3003_3004
3_0_0_0_0000_0005
2_0_0_0_0000_0006
2_0_0_0_0000_0000
1_3_0_0_3005_3006
2_0_0_0_0000_0007
2_0_0_0_0000_0005
2_0_0_0_0000_0006
7_2_0_0_3001_3005
7_1_0_0_3006_0000
// panic, then cmt_ready low, hold retirement
4_0_0_0_0000_0001
1_3_0_0_4001_4002
2_0_0_0_0000_0001
2_0_0_0_0000_0000
6_0_0_0_0000_0005
5_0_0_0_0000_0000
4_0_0_0_0000_0000
6_0_0_0_0000_0004
5_0_0_0_0000_0002
7_2_0_0_4001_4002
// full queue, fifth group waits for two retires
1_3_0_0_5001_5002
1_3_0_0_5003_5004
1_3_0_0_5005_5006
1_3_0_0_5007_5008
2_0_0_0_0000_0002
2_0_0_0_0000_0003
1_3_0_0_5009_500a
2_0_0_0_0000_0004
2_0_0_0_0000_0005
2_0_0_0_0000_0006
2_0_0_0_0000_0007
2_0_0_0_0000_0000
2_0_0_0_0000_0001
2_0_0_0_0000_0002
2_0_0_0_0000_0003
7_2_0_0_5001_5002
7_2_0_0_5003_5004
7_2_0_0_5005_5006
7_2_0_0_5007_5008
7_2_0_0_5009_500a
0_0_0_0_0000_0000

// File: project.f
+incdir+logic
logic/iq_pkg.sv
logic/iq_ctrl.sv
logic/iq_ptrs.sv
logic/iq_valid.sv
logic/iq_store.sv
logic/iq_top.sv
tests/iq_chk.sv
tests/iq_monitor.sv
tests/iq_tb.sv

// File: Makefile
# Verilator build and run for the instruction queue

VERILATOR ?= verilator
TOP       ?= iq_tb
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+100

SRCS := $(filter %.sv %.v,$(shell cat $(FLIST))) $(wildcard logic/*.svh)
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$($(SIM) $(RUN_ARGS))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
